//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_exe
FILELIST  = all.f
BUILD     = obj_dir
SIM       = $(BUILD)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM) tests/exe_vectors.txt
	-$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- all.f
common/core_pkg.sv
common/uop_pkg.sv
exe/exe_alu.sv
exe/exe_mul.sv
exe/exe_forward.sv
exe/exe_stage.sv
tests/exe_assertions.sv
tests/tb_exe.sv

//--- common/core_pkg.sv
package core_pkg;

    // machine word, used for operands, immediates and results
    typedef logic [31:0] word_t;

    // full 64-bit product before word selection
    typedef logic [63:0] dword_t;

    // architectural register number, r0 reads as zero
    typedef logic [4:0] reg_addr_t;

endpackage

//--- common/uop_pkg.sv
package uop_pkg;

    // alu operation of a micro-op
    // shift amount comes from the low 5 bits of the second operand
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_nor  = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_t;

    // word taken from the 64-bit product
    typedef enum logic [1:0] {
        mul_lo  = 2'd0,
        mul_hi  = 2'd1,
        mul_hiu = 2'd2
    } mul_sel_t;

endpackage

//--- exe/exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
    input  uop_pkg::alu_op_t op,
    input  core_pkg::word_t  a,
    input  core_pkg::word_t  b,
    output core_pkg::word_t  result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            uop_pkg::alu_add:  result = a + b;
            uop_pkg::alu_sub:  result = a - b;
            uop_pkg::alu_slt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            uop_pkg::alu_sltu: begin
                result = {31'b0, a < b};
            end
            uop_pkg::alu_and:  result = a & b;
            uop_pkg::alu_or:   result = a | b;
            uop_pkg::alu_nor:  result = ~(a | b);
            uop_pkg::alu_xor:  result = a ^ b;
            uop_pkg::alu_sll:  result = a << shamt;
            uop_pkg::alu_srl:  result = a >> shamt;
            uop_pkg::alu_sra: begin
                result = core_pkg::word_t'($signed(a) >>> shamt);
            end
            // immediate is already shifted by decode
            uop_pkg::alu_lui:  result = b;
            default:           result = '0;
        endcase
    end

endmodule

//--- exe/exe_forward.sv
`timescale 1ns/1ps

module exe_forward (
    input  core_pkg::reg_addr_t rj0,
    input  core_pkg::reg_addr_t rk0,
    input  core_pkg::reg_addr_t rj1,
    input  core_pkg::reg_addr_t rk1,
    input  core_pkg::word_t     rj0_data,
    input  core_pkg::word_t     rk0_data,
    input  core_pkg::word_t     rj1_data,
    input  core_pkg::word_t     rk1_data,
    input  logic                en0,
    input  logic                en1,
    input  logic                mid_en0,
    input  logic                mid_en1,
    input  core_pkg::reg_addr_t mid_rd0,
    input  core_pkg::reg_addr_t mid_rd1,
    input  core_pkg::word_t     mid_data0,
    input  core_pkg::word_t     mid_data1,
    input  logic                out_en0,
    input  logic                out_en1,
    input  core_pkg::reg_addr_t out_rd0,
    input  core_pkg::reg_addr_t out_rd1,
    input  core_pkg::word_t     out_data0,
    input  core_pkg::word_t     out_data1,
    input  logic                mul_valid,
    input  core_pkg::reg_addr_t mul_rd,
    output core_pkg::word_t     op_j0,
    output core_pkg::word_t     op_k0,
    output core_pkg::word_t     op_j1,
    output core_pkg::word_t     op_k1,
    output logic                stall
);

    // later checks overwrite earlier ones, so mid beats out and lane 1 beats lane 0
    function automatic core_pkg::word_t pick(
        input core_pkg::reg_addr_t src,
        input core_pkg::word_t     rf_data
    );
        core_pkg::word_t val;
        val = rf_data;
        if (src != '0) begin
            if (out_en0 && out_rd0 == src) val = out_data0;
            if (out_en1 && out_rd1 == src) val = out_data1;
            if (mid_en0 && mid_rd0 == src) val = mid_data0;
            if (mid_en1 && mid_rd1 == src) val = mid_data1;
        end
        return val;
    endfunction

    always_comb begin
        op_j0 = pick(rj0, rj0_data);
        op_k0 = pick(rk0, rk0_data);
        op_j1 = pick(rj1, rj1_data);
        op_k1 = pick(rk1, rk1_data);
    end

    logic hit_j0;
    logic hit_k0;
    logic hit_j1;
    logic hit_k1;

    // product not ready until the multiply leaves stage 0
    assign hit_j0 = en0 && rj0 != '0 && rj0 == mul_rd;
    assign hit_k0 = en0 && rk0 != '0 && rk0 == mul_rd;
    assign hit_j1 = en1 && rj1 != '0 && rj1 == mul_rd;
    assign hit_k1 = en1 && rk1 != '0 && rk1 == mul_rd;

    assign stall = mul_valid && (hit_j0 || hit_k0 || hit_j1 || hit_k1);

endmodule

//--- exe/exe_mul.sv
`timescale 1ns/1ps

module exe_mul (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                en,
    input  logic                hold,
    input  uop_pkg::mul_sel_t   sel,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::word_t     a,
    input  core_pkg::word_t     b,
    output logic                mid_valid,
    output core_pkg::reg_addr_t mid_rd,
    output core_pkg::word_t     product
);

    core_pkg::word_t pp_ll;
    core_pkg::word_t pp_lh;
    core_pkg::word_t pp_hl;
    core_pkg::word_t pp_hh;
    core_pkg::word_t adj;

    logic                s_valid;
    uop_pkg::mul_sel_t   s_sel;
    core_pkg::reg_addr_t s_rd;
    core_pkg::word_t     s_ll;
    core_pkg::word_t     s_lh;
    core_pkg::word_t     s_hl;
    core_pkg::word_t     s_hh;
    core_pkg::word_t     s_adj;
    core_pkg::dword_t    sum;

    // stage 0, unsigned 16x16 partial products
    assign pp_ll = a[15:0] * b[15:0];
    assign pp_lh = a[15:0] * b[31:16];
    assign pp_hl = a[31:16] * b[15:0];
    assign pp_hh = a[31:16] * b[31:16];

    // signed high word: subtract the other operand for each negative one
    always_comb begin
        adj = '0;
        if (sel != uop_pkg::mul_hiu) begin
            adj = '0 - (a[31] ? b : '0) - (b[31] ? a : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush || hold) begin
            s_valid <= 1'b0;
        end else begin
            s_valid <= en;
        end
        s_sel <= sel;
        s_rd  <= rd;
        s_ll  <= pp_ll;
        s_lh  <= pp_lh;
        s_hl  <= pp_hl;
        s_hh  <= pp_hh;
        s_adj <= adj;
    end

    // stage 1, sum and word select
    assign sum = {s_hh, s_ll} + ({32'b0, s_lh} << 16) + ({32'b0, s_hl} << 16);
    assign product = (s_sel == uop_pkg::mul_lo) ? sum[31:0] : sum[63:32] + s_adj;

    assign mid_valid = s_valid;
    assign mid_rd    = s_rd;

endmodule

//--- exe/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    // lane 0
    input  logic                en0,
    input  core_pkg::reg_addr_t rd0,
    input  core_pkg::reg_addr_t rj0,
    input  core_pkg::reg_addr_t rk0,
    input  core_pkg::word_t     imm0,
    input  logic                use_imm0,
    input  uop_pkg::alu_op_t    alu_op0,
    input  logic                is_mul0,
    input  uop_pkg::mul_sel_t   mul_sel0,
    input  core_pkg::word_t     rj_data0,
    input  core_pkg::word_t     rk_data0,
    // lane 1
    input  logic                en1,
    input  core_pkg::reg_addr_t rd1,
    input  core_pkg::reg_addr_t rj1,
    input  core_pkg::reg_addr_t rk1,
    input  core_pkg::word_t     imm1,
    input  logic                use_imm1,
    input  uop_pkg::alu_op_t    alu_op1,
    input  core_pkg::word_t     rj_data1,
    input  core_pkg::word_t     rk_data1,
    // to issue and writeback
    output logic                stall,
    output logic                wb_en0,
    output core_pkg::reg_addr_t wb_rd0,
    output core_pkg::word_t     wb_data0,
    output logic                wb_en1,
    output core_pkg::reg_addr_t wb_rd1,
    output core_pkg::word_t     wb_data1
);

    core_pkg::word_t op_j0;
    core_pkg::word_t op_k0;
    core_pkg::word_t op_j1;
    core_pkg::word_t op_k1;
    core_pkg::word_t alu_b0;
    core_pkg::word_t alu_b1;
    core_pkg::word_t alu_res0;
    core_pkg::word_t alu_res1;

    // mid register, alu results only
    logic                mid_en0;
    logic                mid_en1;
    core_pkg::reg_addr_t mid_rd0;
    core_pkg::reg_addr_t mid_rd1;
    core_pkg::word_t     mid_data0;
    core_pkg::word_t     mid_data1;

    logic                mul_valid;
    core_pkg::reg_addr_t mul_rd;
    core_pkg::word_t     mul_product;

    exe_forward u_forward (
        .rj0       (rj0),
        .rk0       (rk0),
        .rj1       (rj1),
        .rk1       (rk1),
        .rj0_data  (rj_data0),
        .rk0_data  (rk_data0),
        .rj1_data  (rj_data1),
        .rk1_data  (rk_data1),
        .en0       (en0),
        .en1       (en1),
        .mid_en0   (mid_en0),
        .mid_en1   (mid_en1),
        .mid_rd0   (mid_rd0),
        .mid_rd1   (mid_rd1),
        .mid_data0 (mid_data0),
        .mid_data1 (mid_data1),
        .out_en0   (wb_en0),
        .out_en1   (wb_en1),
        .out_rd0   (wb_rd0),
        .out_rd1   (wb_rd1),
        .out_data0 (wb_data0),
        .out_data1 (wb_data1),
        .mul_valid (mul_valid),
        .mul_rd    (mul_rd),
        .op_j0     (op_j0),
        .op_k0     (op_k0),
        .op_j1     (op_j1),
        .op_k1     (op_k1),
        .stall     (stall)
    );

    assign alu_b0 = use_imm0 ? imm0 : op_k0;
    assign alu_b1 = use_imm1 ? imm1 : op_k1;

    exe_alu u_alu0 (
        .op     (alu_op0),
        .a      (op_j0),
        .b      (alu_b0),
        .result (alu_res0)
    );

    exe_alu u_alu1 (
        .op     (alu_op1),
        .a      (op_j1),
        .b      (alu_b1),
        .result (alu_res1)
    );

    // multiply takes register operands only
    exe_mul u_mul (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .en        (en0 && is_mul0),
        .hold      (stall),
        .sel       (mul_sel0),
        .rd        (rd0),
        .a         (op_j0),
        .b         (op_k0),
        .mid_valid (mul_valid),
        .mid_rd    (mul_rd),
        .product   (mul_product)
    );

    // a stall leaves a bubble, issue holds the pair
    always_ff @(posedge clk) begin
        if (reset || flush || stall) begin
            mid_en0 <= 1'b0;
            mid_en1 <= 1'b0;
        end else begin
            mid_en0 <= en0 && !is_mul0;
            mid_en1 <= en1;
        end
        mid_rd0   <= rd0;
        mid_rd1   <= rd1;
        mid_data0 <= alu_res0;
        mid_data1 <= alu_res1;
    end

    // out register keeps moving during a stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wb_en0 <= 1'b0;
            wb_en1 <= 1'b0;
        end else begin
            wb_en0 <= mid_en0 || mul_valid;
            wb_en1 <= mid_en1;
        end
        wb_rd0   <= mid_rd0;
        wb_data0 <= mul_valid ? mul_product : mid_data0;
        wb_rd1   <= mid_rd1;
        wb_data1 <= mid_data1;
    end

endmodule

//--- tests/exe_assertions.sv
`timescale 1ns/1ps

module exe_assertions (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic stall,
    input logic wb_en0,
    input logic wb_en1
);

    // pipeline comes up empty and issue is not held
    reset_clears_wb: assert property (
        @(posedge clk) $fell(reset) |-> (!wb_en0 && !wb_en1 && !stall)
            ##1 (!wb_en0 && !wb_en1)
    ) else $error("writeback enable or stall high after reset");

    // one bubble per dependent multiply
    stall_single: assert property (
        @(posedge clk) disable iff (reset) stall |=> !stall
    ) else $error("stall held high for two cycles");

    flush_drains: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> (!wb_en0 && !wb_en1) ##1 (!wb_en0 && !wb_en1)
    ) else $error("writeback of a flushed instruction");

endmodule

//--- tests/exe_vectors.txt
// test_flush_en0_rd0_rj0_rk0_imm0_useimm0_op0_ismul0_mulsel0_en1_rd1_rj1_rk1_imm1_useimm1_op1
// one instruction pair per line, ops: 0 add 1 sub 2 slt 3 sltu 4 and 5 or 6 nor 7 xor 8 sll 9 srl a sra b lui
01_0_1_05_01_02_00000000_0_0_0_0_1_06_03_04_00000000_0_1
01_0_1_07_01_02_00000000_0_2_0_0_1_08_03_04_00000000_0_3
01_0_1_09_01_02_00000000_0_4_0_0_1_0a_03_04_00000000_0_5
01_0_1_0b_01_02_00000000_0_6_0_0_1_0c_03_04_00000000_0_7
01_0_1_0d_01_02_00000000_0_8_0_0_1_0e_03_04_00000000_0_9
01_0_1_0f_01_02_00000000_0_a_0_0_1_10_03_04_00000000_0_b
02_0_1_11_01_00_fffff800_1_0_0_0_1_12_02_00_00000123_1_1
02_0_1_13_03_00_80000000_1_2_0_0_1_14_04_00_ffffffff_1_3
02_0_1_15_01_00_0000ffff_1_4_0_0_1_16_02_00_0f0f0000_1_5
02_0_1_17_03_00_0000001f_1_8_0_0_1_18_04_00_00000004_1_a
02_0_1_19_00_00_12345000_1_b_0_0_1_1a_01_00_00000011_1_9
02_0_1_05_03_00_00ff00ff_1_6_0_0_1_06_04_00_a5a5a5a5_1_7
03_0_1_1b_00_00_80000000_1_b_0_0_1_1c_00_00_ffffffff_1_b
03_0_1_1d_00_00_fffffff9_1_0_0_0_1_1e_00_00_7fffffff_1_b
03_0_1_07_1b_1c_00000000_0_0_1_0_0_00_00_00_00000000_0_0
03_0_1_08_1b_1c_00000000_0_0_1_1_1_09_1d_1e_00000000_0_0
03_0_1_0a_1b_1c_00000000_0_0_1_2_0_00_00_00_00000000_0_0
03_0_1_0b_1d_1e_00000000_0_0_1_1_0_00_00_00_00000000_0_0
03_0_1_0c_1d_1c_00000000_0_0_1_2_0_00_00_00_00000000_0_0
03_0_1_0d_1b_1b_00000000_0_0_1_0_0_00_00_00_00000000_0_0
03_0_1_0e_1c_1c_00000000_0_0_1_1_0_00_00_00_00000000_0_0
04_0_1_01_02_00_00000001_1_0_0_0_1_03_04_00_00000002_1_0
04_0_1_05_01_03_00000000_0_0_0_0_1_06_01_03_00000000_0_1
04_0_1_07_05_01_00000000_0_7_0_0_1_08_06_03_00000000_0_5
04_0_1_01_07_08_00000000_0_0_0_0_1_02_08_06_00000000_0_0
04_0_1_09_01_02_00000000_0_4_0_0_1_0a_01_02_00000000_0_6
05_0_1_0b_1b_1d_00000000_0_0_1_0_1_0c_01_00_00000005_1_0
05_0_1_0d_0b_0c_00000000_0_0_0_0_1_0e_0b_00_00000000_1_0
05_0_1_0f_0d_1c_00000000_0_0_1_1_0_00_00_00_00000000_0_0
05_0_0_00_00_00_00000000_0_0_0_0_1_10_0f_0d_00000000_0_3
05_0_1_11_0f_10_00000000_0_0_0_0_1_12_10_00_00000003_1_8
06_0_1_14_00_00_00000011_1_0_0_0_1_15_00_00_00000022_1_0
06_0_1_14_14_00_00000001_1_0_0_0_1_15_15_00_00000001_1_0
06_1_1_16_14_15_00000000_0_0_0_0_1_17_14_00_000000ff_1_7
06_0_1_17_14_15_00000000_0_0_0_0_1_18_14_00_000000ff_1_7
06_0_1_19_17_18_00000000_0_0_0_0_1_1a_17_18_00000000_0_1

//--- tests/tb_exe.sv
`timescale 1ns/1ps

module tb_exe;

    logic                clk;
    logic                reset;
    logic                flush;
    logic                en0;
    core_pkg::reg_addr_t rd0;
    core_pkg::reg_addr_t rj0;
    core_pkg::reg_addr_t rk0;
    core_pkg::word_t     imm0;
    logic                use_imm0;
    uop_pkg::alu_op_t    alu_op0;
    logic                is_mul0;
    uop_pkg::mul_sel_t   mul_sel0;
    core_pkg::word_t     rj_data0;
    core_pkg::word_t     rk_data0;
    logic                en1;
    core_pkg::reg_addr_t rd1;
    core_pkg::reg_addr_t rj1;
    core_pkg::reg_addr_t rk1;
    core_pkg::word_t     imm1;
    logic                use_imm1;
    uop_pkg::alu_op_t    alu_op1;
    core_pkg::word_t     rj_data1;
    core_pkg::word_t     rk_data1;
    logic                stall;
    logic                wb_en0;
    core_pkg::reg_addr_t wb_rd0;
    core_pkg::word_t     wb_data0;
    logic                wb_en1;
    core_pkg::reg_addr_t wb_rd1;
    core_pkg::word_t     wb_data1;

    logic [155:0]    vec [0:63];
    // program order view and the view the register file has after writeback
    core_pkg::word_t model_rf [0:31];
    core_pkg::word_t retired_rf [0:31];
    core_pkg::word_t before_prev [0:31];
    // entry is test, rd, data
    logic [44:0]     exp_q0 [$];
    logic [44:0]     exp_q1 [$];
    int              due_q0 [$];
    int              due_q1 [$];
    int              checks [0:255];
    int              errs [0:255];
    int              prev_push0;
    int              prev_push1;
    int              stray_errs;
    int              cycles;
    int              last_test;
    int              passed;
    int              failed;
    logic            pend_en0;
    logic            pend_en1;
    logic [36:0]     pend0;
    logic [36:0]     pend1;
    // multiply accepted in the previous cycle
    logic            mul_prev;
    core_pkg::reg_addr_t mul_rd_prev;

    exe_stage dut0 (.*);

    bind exe_stage exe_assertions u_assertions (
        .clk    (clk),
        .reset  (reset),
        .flush  (flush),
        .stall  (stall),
        .wb_en0 (wb_en0),
        .wb_en1 (wb_en1)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic core_pkg::word_t alu_model(
        input logic [3:0] op,
        input core_pkg::word_t a,
        input core_pkg::word_t b
    );
        core_pkg::word_t r;
        case (op)
            uop_pkg::alu_add:  r = a + b;
            uop_pkg::alu_sub:  r = a - b;
            uop_pkg::alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            uop_pkg::alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
            uop_pkg::alu_and:  r = a & b;
            uop_pkg::alu_or:   r = a | b;
            uop_pkg::alu_nor:  r = ~(a | b);
            uop_pkg::alu_xor:  r = a ^ b;
            uop_pkg::alu_sll:  r = a << b[4:0];
            uop_pkg::alu_srl:  r = a >> b[4:0];
            uop_pkg::alu_sra:  r = $signed(a) >>> b[4:0];
            uop_pkg::alu_lui:  r = b;
            default:           r = '0;
        endcase
        return r;
    endfunction

    function automatic core_pkg::word_t mul_model(
        input logic [1:0] sel,
        input core_pkg::word_t a,
        input core_pkg::word_t b
    );
        logic [63:0] p;
        if (sel == uop_pkg::mul_hiu) begin
            p = {32'b0, a} * {32'b0, b};
        end else begin
            p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        end
        return (sel == uop_pkg::mul_lo) ? p[31:0] : p[63:32];
    endfunction

    // a source naming last cycle's multiply destination has to wait a cycle
    function automatic logic stall_expected(input logic [155:0] v);
        logic hit;
        hit = 1'b0;
        if (mul_prev && mul_rd_prev != '0) begin
            if (v[140] && (v[128:124] == mul_rd_prev || v[120:116] == mul_rd_prev)) begin
                hit = 1'b1;
            end
            if (v[64] && (v[52:48] == mul_rd_prev || v[44:40] == mul_rd_prev)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic drive_pair(input logic [155:0] v);
        flush    = v[144];
        en0      = v[140];
        rd0      = v[136:132];
        rj0      = v[128:124];
        rk0      = v[120:116];
        imm0     = v[115:84];
        use_imm0 = v[80];
        alu_op0  = uop_pkg::alu_op_t'(v[79:76]);
        is_mul0  = v[72];
        mul_sel0 = uop_pkg::mul_sel_t'(v[69:68]);
        en1      = v[64];
        rd1      = v[60:56];
        rj1      = v[52:48];
        rk1      = v[44:40];
        imm1     = v[39:8];
        use_imm1 = v[4];
        alu_op1  = uop_pkg::alu_op_t'(v[3:0]);
        // register file read, redone every cycle while held
        rj_data0 = retired_rf[rj0];
        rk_data0 = retired_rf[rk0];
        rj_data1 = retired_rf[rj1];
        rk_data1 = retired_rf[rk1];
    endtask

    task automatic accept_pair(input logic [155:0] v);
        core_pkg::word_t b0;
        core_pkg::word_t b1;
        core_pkg::word_t r0;
        core_pkg::word_t r1;
        if (v[144]) begin
            // the previous pair and this one never retire
            if (prev_push0 != 0) begin
                exp_q0.delete(exp_q0.size() - 1);
                due_q0.delete(due_q0.size() - 1);
            end
            if (prev_push1 != 0) begin
                exp_q1.delete(exp_q1.size() - 1);
                due_q1.delete(due_q1.size() - 1);
            end
            model_rf = before_prev;
            prev_push0 = 0;
            prev_push1 = 0;
            mul_prev = 1'b0;
        end else begin
            before_prev = model_rf;
            b0 = v[80] ? v[115:84] : model_rf[v[120:116]];
            b1 = v[4] ? v[39:8] : model_rf[v[44:40]];
            if (v[72]) begin
                r0 = mul_model(v[69:68], model_rf[v[128:124]], model_rf[v[120:116]]);
            end else begin
                r0 = alu_model(v[79:76], model_rf[v[128:124]], b0);
            end
            r1 = alu_model(v[3:0], model_rf[v[52:48]], b1);
            prev_push0 = v[140];
            prev_push1 = v[64];
            mul_prev = v[140] && v[72];
            mul_rd_prev = v[136:132];
            if (v[140]) begin
                exp_q0.push_back({v[155:148], v[136:132], r0});
                due_q0.push_back(cycles + 2);
                model_rf[v[136:132]] = r0;
            end
            if (v[64]) begin
                exp_q1.push_back({v[155:148], v[60:56], r1});
                due_q1.push_back(cycles + 2);
                model_rf[v[60:56]] = r1;
            end
            model_rf[0] = '0;
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d: %0d writebacks, %0d errors", t, checks[t], errs[t]);
        if (errs[t] == 0) begin
            passed++;
        end else begin
            failed++;
        end
    endtask

    task automatic check_wb(
        input int lane,
        input logic en,
        input core_pkg::reg_addr_t rd,
        input core_pkg::word_t data
    );
        logic [44:0] e;
        int          due;
        int          t;
        logic        have;
        have = 1'b0;
        if (en && lane == 0 && exp_q0.size() != 0) begin
            e = exp_q0.pop_front();
            due = due_q0.pop_front();
            have = 1'b1;
        end else if (en && lane == 1 && exp_q1.size() != 0) begin
            e = exp_q1.pop_front();
            due = due_q1.pop_front();
            have = 1'b1;
        end
        if (en && !have) begin
            $display("lane %0d wrote back r%0d with no instruction in flight", lane, rd);
            stray_errs++;
        end else if (have) begin
            t = e[44:37];
            // writebacks retire in order, so a new test number closes the previous test
            if (t != last_test) begin
                if (last_test != 0) begin
                    report_test(last_test);
                end
                last_test = t;
            end
            checks[t]++;
            if (rd !== e[36:32]) begin
                $display("[FAIL] wb_rd%0d got %h expected %h", lane, rd, e[36:32]);
                errs[t]++;
            end
            if (data !== e[31:0]) begin
                $display("[FAIL] wb_data%0d got %h expected %h", lane, data, e[31:0]);
                errs[t]++;
            end
            if (cycles != due) begin
                $display("lane %0d writeback came at cycle %0d instead of cycle %0d",
                         lane, cycles, due);
                errs[t]++;
            end
            if (lane == 0) begin
                pend_en0 = 1'b1;
                pend0 = e[36:0];
            end else begin
                pend_en1 = 1'b1;
                pend1 = e[36:0];
            end
        end
    endtask

    initial begin
        int nvec;
        int idx;
        int limit;
        logic [31:0] rng;
        logic exp_stall;
        clk = 1'b0;
        reset = 1'b1;
        for (int i = 0; i < 64; i++) begin
            vec[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            checks[i] = 0;
            errs[i] = 0;
        end
        $readmemh("tests/exe_vectors.txt", vec);
        nvec = 0;
        while (nvec < 64 && vec[nvec][155:148] != 8'd0) begin
            nvec++;
        end
        limit = 4 * nvec + 100;
        rng = 32'h580a;
        for (int r = 0; r < 32; r++) begin
            rng = xorshift(rng);
            model_rf[r] = (r == 0) ? '0 : rng;
            retired_rf[r] = model_rf[r];
        end
        drive_pair('0);
        before_prev = model_rf;
        prev_push0 = 0;
        prev_push1 = 0;
        stray_errs = 0;
        cycles = 0;
        last_test = 0;
        passed = 0;
        failed = 0;
        pend_en0 = 1'b0;
        pend_en1 = 1'b0;
        mul_prev = 1'b0;
        mul_rd_prev = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        idx = 0;
        while ((idx < nvec || exp_q0.size() != 0 || exp_q1.size() != 0) && cycles <= limit) begin
            // writes seen last cycle land in the register file at this edge
            if (pend_en0) retired_rf[pend0[36:32]] = pend0[31:0];
            if (pend_en1) retired_rf[pend1[36:32]] = pend1[31:0];
            retired_rf[0] = '0;
            pend_en0 = 1'b0;
            pend_en1 = 1'b0;
            check_wb(0, wb_en0, wb_rd0, wb_data0);
            check_wb(1, wb_en1, wb_rd1, wb_data1);
            drive_pair(idx < nvec ? vec[idx] : '0);
            @(negedge clk);
            if (idx < nvec) begin
                exp_stall = stall_expected(vec[idx]);
                if (stall !== exp_stall) begin
                    $display("[FAIL] stall got %h expected %h", stall, exp_stall);
                    errs[vec[idx][155:148]]++;
                end
            end
            if (idx < nvec && (!stall || flush)) begin
                accept_pair(vec[idx]);
                idx++;
            end else begin
                mul_prev = 1'b0;
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        if (cycles > limit) begin
            $display("timeout after %0d cycles with %0d writebacks outstanding",
                     cycles, exp_q0.size() + exp_q1.size());
            $display("RESULT: FAIL");
        end else begin
            // idle a few cycles to catch stray writebacks
            repeat (3) begin
                check_wb(0, wb_en0, wb_rd0, wb_data0);
                check_wb(1, wb_en1, wb_rd1, wb_data1);
                @(posedge clk);
                #2;
                cycles++;
            end
            if (last_test != 0) begin
                report_test(last_test);
            end
            $display("tests passed %0d failed %0d stray writebacks %0d",
                     passed, failed, stray_errs);
            if (failed == 0 && stray_errs == 0 && passed != 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule
